//--- dv/clkGen.sv
`timescale 1ns/10ps

module clkGen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    // Reset held over the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- dv/icacheTb.sv
`timescale 1ns/10ps

module icacheTb;
    import icachePkg::*;

    localparam int waitLimit = 50;
    localparam int stallCycles = 4;

    logic clk;
    logic rst;
    logic rdy;
    logic fetchEn;
    addrT addr;
    logic memValid;
    instT memInst;
    logic hit;
    instT foundInst;
    logic memFetchEn;
    addrT memFetchAddr;

    // Stimulus table with the expected first lookup outcome
    string names [$];
    addrT  addrs [$];
    logic  rdys [$];
    logic  hits [$];

    // Reference model of tags, valid bits and LRU bits
    logic modelValid [2][numSets];
    tagT  modelTag [2][numSets];
    wayT  modelLru [numSets];

    int   errorCount = 0;
    int   passCount = 0;
    int   failCount = 0;
    int   assertFails;
    logic timedOut = 1'b0;

    clkGen clocks (.clk(clk), .rst(rst));

    instMem memory (
        .clk          (clk),
        .rst          (rst),
        .memFetchEn   (memFetchEn),
        .memFetchAddr (memFetchAddr),
        .memValid     (memValid),
        .memInst      (memInst)
    );

    icache icache_inst (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .fetchEn      (fetchEn),
        .addr         (addr),
        .memValid     (memValid),
        .memInst      (memInst),
        .hit          (hit),
        .foundInst    (foundInst),
        .memFetchEn   (memFetchEn),
        .memFetchAddr (memFetchAddr)
    );

    task automatic addEntry(input string name, input addrT a, input logic r, input logic h);
        names.push_back(name);
        addrs.push_back(a);
        rdys.push_back(r);
        hits.push_back(h);
    endtask

    task automatic resetModel();
        for (int s = 0; s < numSets; s++) begin
            modelValid[0][s] = 1'b0;
            modelValid[1][s] = 1'b0;
            modelLru[s] = 1'b0;
        end
    endtask

    function automatic logic predictHit(input addrT a);
        indexT idx;
        tagT   tag;
        idx = a[7:2];
        tag = a[31:8];
        return (modelValid[0][idx] && modelTag[0][idx] == tag) ||
               (modelValid[1][idx] && modelTag[1][idx] == tag);
    endfunction

    // A hit or a refill leaves the other way as least recently used
    function automatic void updateModel(input addrT a);
        indexT idx;
        tagT   tag;
        wayT   victim;
        idx = a[7:2];
        tag = a[31:8];
        if (modelValid[0][idx] && modelTag[0][idx] == tag) begin
            modelLru[idx] = 1'b1;
        end else if (modelValid[1][idx] && modelTag[1][idx] == tag) begin
            modelLru[idx] = 1'b0;
        end else begin
            if (!modelValid[0][idx]) begin
                victim = 1'b0;
            end else if (!modelValid[1][idx]) begin
                victim = 1'b1;
            end else begin
                victim = modelLru[idx];
            end
            modelValid[victim][idx] = 1'b1;
            modelTag[victim][idx] = tag;
            modelLru[idx] = ~victim;
        end
    endfunction

    task automatic checkInst(input string name, input instT expVal, input instT actVal);
        if (actVal !== expVal) begin
            $display("[FAIL] %0s foundInst expected %h actual %h", name, expVal, actVal);
            errorCount++;
        end
    endtask

    task automatic checkAddr(input string name, input addrT expVal, input addrT actVal);
        if (actVal !== expVal) begin
            $display("[FAIL] %0s memFetchAddr expected %h actual %h", name, expVal, actVal);
            errorCount++;
        end
    endtask

    task automatic checkHit(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("[FAIL] %0s expected %b actual %b", name, expVal, actVal);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string name, input int errsBefore);
        if (errorCount == errsBefore) begin
            passCount++;
            $display("%0s: passed", name);
        end else begin
            failCount++;
            $display("%0s: failed with %0d errors", name, errorCount - errsBefore);
        end
    endtask

    task automatic runTest(input int i);
        addrT aligned;
        addrT reqAddr;
        logic expHit;
        logic firstHit;
        int   reqCount;
        int   cycles;
        int   errsBefore;
        errsBefore = errorCount;
        aligned = {addrs[i][31:2], 2'b00};
        expHit = predictHit(addrs[i]);
        reqCount = 0;
        reqAddr = '0;
        if (expHit !== hits[i]) begin
            $display("%0s: table entry disagrees with the reference model", names[i]);
            errorCount++;
        end
        @(posedge clk);
        fetchEn <= 1'b1;
        addr <= addrs[i];
        rdy <= rdys[i];
        @(negedge clk);
        firstHit = hit;
        if (!rdys[i]) begin
            repeat (stallCycles) begin
                if (memFetchEn) reqCount++;
                @(negedge clk);
            end
            if (reqCount != 0) begin
                $display("%0s: a memory request went out while rdy was low", names[i]);
                errorCount++;
            end
            @(posedge clk);
            rdy <= 1'b1;
            @(negedge clk);
        end
        cycles = 0;
        while (!hit && cycles < waitLimit) begin
            if (memFetchEn) begin
                reqCount++;
                reqAddr = memFetchAddr;
            end
            @(negedge clk);
            cycles++;
        end
        if (!hit) begin
            $display("%0s: no hit within %0d cycles", names[i], waitLimit);
            errorCount++;
            timedOut = 1'b1;
        end else begin
            checkHit({names[i], " first lookup hit"}, expHit, firstHit);
            if (reqCount != (expHit ? 0 : 1)) begin
                $display("%0s: saw %0d memory requests instead of %0d", names[i], reqCount,
                         expHit ? 0 : 1);
                errorCount++;
            end
            if (!expHit) checkAddr(names[i], aligned, reqAddr);
            checkInst(names[i], ~aligned, foundInst);
            updateModel(addrs[i]);
        end
        @(posedge clk);
        fetchEn <= 1'b0;
        finishTest(names[i], errsBefore);
    endtask

    initial begin
        int resetWait;
        int errsBefore;
        fetchEn = 1'b0;
        addr = '0;
        rdy = 1'b1;
        resetModel();

        // Set 1 holds three conflicting tags to exercise the LRU choice
        addEntry("cold miss after reset", 32'h0000_0042, 1'b1, 1'b0);
        addEntry("cold line hits", 32'h0000_0040, 1'b1, 1'b1);
        addEntry("fill way 0", 32'h0000_1004, 1'b1, 1'b0);
        addEntry("fill way 1", 32'h0000_2006, 1'b1, 1'b0);
        addEntry("first tag resident", 32'h0000_1004, 1'b1, 1'b1);
        addEntry("second tag resident", 32'h0000_2004, 1'b1, 1'b1);
        addEntry("first tag used again", 32'h0000_1005, 1'b1, 1'b1);
        addEntry("third tag evicts", 32'h0000_3004, 1'b1, 1'b0);
        addEntry("recent tag survives", 32'h0000_1004, 1'b1, 1'b1);
        addEntry("evicted tag misses", 32'h0000_2004, 1'b1, 1'b0);
        addEntry("used tag kept", 32'h0000_1004, 1'b1, 1'b1);
        addEntry("stalled miss", 32'h0000_5108, 1'b0, 1'b0);
        addEntry("stalled line hits", 32'h0000_5108, 1'b1, 1'b1);

        resetWait = 0;
        while (rst !== 1'b0 && resetWait < 20) begin
            @(posedge clk);
            resetWait++;
        end
        if (rst !== 1'b0) begin
            $display("Reset never released");
            timedOut = 1'b1;
        end

        errsBefore = errorCount;
        @(negedge clk);
        checkHit("after reset hit", 1'b0, hit);
        checkHit("after reset memFetchEn", 1'b0, memFetchEn);
        finishTest("after reset", errsBefore);

        for (int i = 0; i < names.size() && !timedOut; i++) begin
            runTest(i);
        end

        assertFails = icache_inst.chkInst.pulseFails + icache_inst.chkInst.riseFails +
                      icache_inst.chkInst.alignFails + icache_inst.chkInst.freeFails;
        $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
                 passCount, failCount, assertFails);
        if (failCount == 0 && assertFails == 0 && !timedOut) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- dv/icache_chk.sv
`timescale 1ns/10ps

module icache_chk (
    input logic             clk,
    input logic             rst,
    input logic             hit,
    input icachePkg::instT  foundInst,
    input logic             memFetchEn,
    input icachePkg::addrT  memFetchAddr
);
    import icachePkg::*;

    int pulseFails = 0;
    int riseFails = 0;
    int alignFails = 0;
    int freeFails = 0;

    reqPulse: assert property (@(posedge clk) disable iff (rst) memFetchEn |=> !memFetchEn)
        else begin
            $error("memFetchEn stayed high for more than one cycle");
            pulseFails = pulseFails + 1;
        end

    // A resident address must never go out to memory
    reqNoHit: assert property (@(posedge clk) disable iff (rst) $rose(memFetchEn) |-> !hit)
        else begin
            $error("memFetchEn rose while hit was high");
            riseFails = riseFails + 1;
        end

    reqAlign: assert property (@(posedge clk) disable iff (rst)
            memFetchEn |-> (memFetchAddr[1:0] == 2'b00))
        else begin
            $error("memFetchAddr is not word aligned");
            alignFails = alignFails + 1;
        end

    missData: assert property (@(posedge clk) disable iff (rst) !hit |-> (foundInst == instFree))
        else begin
            $error("foundInst is not the free value while hit is low");
            freeFails = freeFails + 1;
        end

endmodule

bind icache icache_chk chkInst (
    .clk          (clk),
    .rst          (rst),
    .hit          (hit),
    .foundInst    (foundInst),
    .memFetchEn   (memFetchEn),
    .memFetchAddr (memFetchAddr)
);

//--- dv/instMem.sv
`timescale 1ns/10ps

module instMem (
    input  logic             clk,
    input  logic             rst,
    input  logic             memFetchEn,
    input  icachePkg::addrT  memFetchAddr,
    output logic             memValid,
    output icachePkg::instT  memInst
);
    import icachePkg::*;

    integer seed = 46500;
    addrT   reqAddr;
    int     remaining;
    logic   busy;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            memValid  <= 1'b0;
            memInst   <= '0;
            reqAddr   <= '0;
            remaining <= 0;
            busy      <= 1'b0;
        end else begin
            memValid <= 1'b0;
            if (memFetchEn && !busy) begin
                reqAddr   <= memFetchAddr;
                remaining <= 1 + ($unsigned($random(seed)) % 6); // Between 1 and 6 cycles
                busy      <= 1'b1;
            end else if (busy) begin
                if (remaining == 1) begin
                    memValid <= 1'b1;
                    memInst  <= ~reqAddr; // Word content is the inverted address
                    busy     <= 1'b0;
                end else begin
                    remaining <= remaining - 1;
                end
            end
        end
    end

endmodule

//--- rtl/cacheWay.sv
`timescale 1ns/10ps

module cacheWay (
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,
    input  icachePkg::addrT  addr,
    input  logic             refillEn,
    input  icachePkg::addrT  refillAddr,
    input  icachePkg::instT  refillInst,
    output logic             wayHit,
    output icachePkg::instT  wayInst,
    output logic             validAtRefill
);
    import icachePkg::*;

    logic [numSets-1:0] valid;
    tagT                tags [numSets];
    instT               insts [numSets];

    indexT fetchIndex;
    indexT refillIndex;
    tagT   fetchTag;

    assign fetchIndex  = indexOf(addr);
    assign fetchTag    = tagOf(addr);
    assign refillIndex = indexOf(refillAddr);

    // Lookup is purely combinational so the fetch sees its word in the same cycle
    assign wayHit  = valid[fetchIndex] && (tags[fetchIndex] == fetchTag);
    assign wayInst = insts[fetchIndex];

    // The LRU table needs to know if this way is free at the set being refilled
    assign validAtRefill = valid[refillIndex];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (rdy && refillEn) begin
            valid[refillIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && refillEn) begin
            tags[refillIndex]  <= tagOf(refillAddr);
            insts[refillIndex] <= refillInst; // Word returned by instruction memory
        end
    end

endmodule

//--- rtl/icache.sv
`timescale 1ns/10ps

module icache (
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,
    input  logic             fetchEn,
    input  icachePkg::addrT  addr,
    input  logic             memValid,
    input  icachePkg::instT  memInst,
    output logic             hit,
    output icachePkg::instT  foundInst,
    output logic             memFetchEn,
    output icachePkg::addrT  memFetchAddr
);
    import icachePkg::*;

    logic  wayHit0;
    logic  wayHit1;
    instT  wayInst0;
    instT  wayInst1;
    logic  valid0;
    logic  valid1;
    wayT   victimWay;
    logic  refillEn;
    logic  refillEn0;
    logic  refillEn1;
    addrT  refillAddr;
    instT  refillInst;
    logic  touchEn;
    wayT   touchWay;
    indexT touchIndex;

    // Only the victim way takes the refill
    assign refillEn0 = refillEn && (victimWay == 1'b0);
    assign refillEn1 = refillEn && (victimWay == 1'b1);

    cacheWay way0 (
        .clk           (clk),
        .rst           (rst),
        .rdy           (rdy),
        .addr          (addr),
        .refillEn      (refillEn0),
        .refillAddr    (refillAddr),
        .refillInst    (refillInst),
        .wayHit        (wayHit0),
        .wayInst       (wayInst0),
        .validAtRefill (valid0)
    );

    cacheWay way1 (
        .clk           (clk),
        .rst           (rst),
        .rdy           (rdy),
        .addr          (addr),
        .refillEn      (refillEn1),
        .refillAddr    (refillAddr),
        .refillInst    (refillInst),
        .wayHit        (wayHit1),
        .wayInst       (wayInst1),
        .validAtRefill (valid1)
    );

    assign hit = wayHit0 || wayHit1;

    always_comb begin
        if (wayHit0) begin
            foundInst = wayInst0;
        end else if (wayHit1) begin
            foundInst = wayInst1;
        end else begin
            foundInst = instFree;
        end
    end

    // A refill touches the victim and a hit touches the hitting way
    assign touchEn    = refillEn || (fetchEn && hit);
    assign touchWay   = refillEn ? victimWay : wayHit1;
    assign touchIndex = refillEn ? indexOf(refillAddr) : indexOf(addr);

    lruTable lru (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .touchEn     (touchEn),
        .touchIndex  (touchIndex),
        .touchWay    (touchWay),
        .refillIndex (indexOf(refillAddr)),
        .valid0      (valid0),
        .valid1      (valid1),
        .victimWay   (victimWay)
    );

    missHandler miss (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .fetchEn      (fetchEn),
        .addr         (addr),
        .hit          (hit),
        .memValid     (memValid),
        .memInst      (memInst),
        .memFetchEn   (memFetchEn),
        .memFetchAddr (memFetchAddr),
        .refillEn     (refillEn),
        .refillAddr   (refillAddr),
        .refillInst   (refillInst)
    );

endmodule

//--- rtl/icachePkg.sv
package icachePkg;

    localparam int addrWidth = 32;
    localparam int instWidth = 32;
    localparam int numSets = 64;
    localparam int indexWidth = 6;
    localparam int offsetWidth = 2;
    localparam int tagWidth = addrWidth - indexWidth - offsetWidth;

    typedef logic [addrWidth-1:0] addrT;
    typedef logic [instWidth-1:0] instT;
    typedef logic [indexWidth-1:0] indexT;
    typedef logic [tagWidth-1:0] tagT;
    typedef logic wayT;

    // Driven on foundInst whenever neither way hits
    localparam instT instFree = '0;

    // Set index sits just above the byte offset within the word
    function automatic indexT indexOf(input addrT a);
        return a[offsetWidth +: indexWidth];
    endfunction

    function automatic tagT tagOf(input addrT a);
        return a[addrWidth-1 -: tagWidth];
    endfunction

endpackage

//--- rtl/lruTable.sv
`timescale 1ns/10ps

module lruTable (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              touchEn,
    input  icachePkg::indexT  touchIndex,
    input  icachePkg::wayT    touchWay,
    input  icachePkg::indexT  refillIndex,
    input  logic              valid0,
    input  logic              valid1,
    output icachePkg::wayT    victimWay
);
    import icachePkg::*;

    // One bit per set holding the least recently used way
    logic [numSets-1:0] lru;

    // Free ways are filled before anything is evicted, way 0 first
    always_comb begin
        if (!valid0) begin
            victimWay = 1'b0;
        end else if (!valid1) begin
            victimWay = 1'b1;
        end else begin
            victimWay = lru[refillIndex];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lru <= '0;
        end else if (rdy && touchEn) begin
            lru[touchIndex] <= ~touchWay; // The other way becomes the older one
        end
    end

endmodule

//--- rtl/missHandler.sv
`timescale 1ns/10ps

module missHandler (
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,
    input  logic             fetchEn,
    input  icachePkg::addrT  addr,
    input  logic             hit,
    input  logic             memValid,
    input  icachePkg::instT  memInst,
    output logic             memFetchEn,
    output icachePkg::addrT  memFetchAddr,
    output logic             refillEn,
    output icachePkg::addrT  refillAddr,
    output icachePkg::instT  refillInst
);
    import icachePkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stRequest,
        stWait
    } stateT;

    stateT state;
    addrT  missAddr;
    logic  pendValid;
    instT  pendInst;
    logic  startMiss;
    logic  respIn;

    // A new miss is only taken while idle so there is never more than one outstanding
    assign startMiss = (state == stIdle) && fetchEn && !hit;

    // Response either arrives now or was caught earlier during a stall
    assign respIn = (state == stWait) && (memValid || pendValid);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= stIdle;
            pendValid <= 1'b0;
        end else if (rdy) begin
            case (state)
                stIdle: begin
                    if (startMiss) begin
                        state <= stRequest;
                    end
                end
                stRequest: begin
                    state <= stWait; // Memory always takes the request
                end
                stWait: begin
                    if (respIn) begin
                        state     <= stIdle;
                        pendValid <= 1'b0;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end else if ((state == stWait) && memValid) begin
            pendValid <= 1'b1; // Hold the response until rdy comes back
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && startMiss) begin
            missAddr <= {tagOf(addr), indexOf(addr), {offsetWidth{1'b0}}};
        end
        if (!rdy && (state == stWait) && memValid) begin
            pendInst <= memInst;
        end
    end

    assign memFetchEn   = (state == stRequest) && rdy;
    assign memFetchAddr = missAddr;

    // Refill strobe lines up with the memValid edge itself
    assign refillEn   = respIn;
    assign refillAddr = missAddr;
    assign refillInst = pendValid ? pendInst : memInst;

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module icacheTb \
    -f vlog.f -o icacheSim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/icacheSim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

//--- vlog.f
rtl/icachePkg.sv
rtl/cacheWay.sv
rtl/lruTable.sv
rtl/missHandler.sv
rtl/icache.sv
dv/clkGen.sv
dv/instMem.sv
dv/icache_chk.sv
dv/icacheTb.sv
